//--- ita_pkg.sv
//########################################
// shared widths, typedefs, step/layer enums
// control and beat-position structs
//########################################

package ita_pkg;

  typedef logic [15:0] dim_t;    // matrix dimension or element index
  typedef logic [7:0]  count_t;  // beat inside an inner tile
  typedef logic [7:0]  tile_t;   // tile count or tile index
  typedef logic [23:0] bias_t;   // one lane bias

  typedef enum logic [1:0] {
    layer_linear,
    layer_feedforward
  } layer_e;

  // linear runs matmul only and feedforward runs f1 then f2
  typedef enum logic [1:0] {
    step_idle,
    step_matmul,
    step_f1,
    step_f2
  } step_e;

  typedef struct packed {
    logic   start;
    layer_e layer;
    dim_t   seq_length;
    dim_t   proj_space;
    dim_t   embed_size;
    dim_t   ff_size;
    tile_t  tile_s;  // row tiles
    tile_t  tile_e;
    tile_t  tile_p;
    tile_t  tile_f;
  } ctrl_t;

  // position of the beat accepted in this cycle
  typedef struct packed {
    logic valid;
    logic row_oob;    // row at or past seq_length
    dim_t col_base;   // column of lane 0
    dim_t col_limit;  // output columns of the step
  } beat_pos_t;

endpackage

//--- tile_sequencer.sv
//########################################
// step FSM, beat/inner/output tile counters
// input join and outstanding-result stall
//########################################

`timescale 1ns/100ps

module tile_sequencer #(
  parameter int unsigned N_LANES    = 4,
  parameter int unsigned TILE_DIM   = 8,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ita_pkg::ctrl_t     ctrl_i,
  input  logic               inp_valid_i,
  input  logic               weight_valid_i,
  input  logic               bias_valid_i,
  input  logic               oup_valid_i,
  input  logic               oup_ready_i,
  output logic               inp_ready_o,
  output logic               weight_ready_o,
  output logic               bias_ready_o,
  output logic               calc_en_o,
  output logic               busy_o,
  output logic               first_inner_tile_o,
  output logic               last_inner_tile_o,
  output ita_pkg::step_e     step_o,
  output ita_pkg::tile_t     tile_x_o,
  output ita_pkg::tile_t     tile_y_o,
  output ita_pkg::tile_t     inner_tile_o,
  output ita_pkg::beat_pos_t beat_pos_o
);
  import ita_pkg::*;

  localparam int unsigned BEATS = TILE_DIM * TILE_DIM / N_LANES;  // beats per inner tile
  localparam int unsigned OW    = $clog2(FIFO_DEPTH + 1);

  step_e         step_d, step_q;
  count_t        count_d, count_q;
  tile_t         inner_d, inner_q;
  tile_t         tile_x_d, tile_x_q;
  tile_t         tile_y_d, tile_y_q;
  logic [OW-1:0] ongoing_d, ongoing_q;  // results still in the output FIFO

  tile_t n_inner;
  tile_t n_tile_x;
  dim_t  col_limit;
  dim_t  row;
  dim_t  col_base;
  logic  active;
  logic  stall;
  logic  accept;
  logic  last_inner;
  logic  push;
  logic  pop;

  // per-step loop bounds with matmul as default
  always_comb begin
    n_inner   = ctrl_i.tile_e;
    n_tile_x  = ctrl_i.tile_p;
    col_limit = ctrl_i.proj_space;
    case (step_q)
      step_f1: begin
        n_tile_x  = ctrl_i.tile_f;
        col_limit = ctrl_i.ff_size;
      end
      step_f2: begin
        n_inner   = ctrl_i.tile_f;
        n_tile_x  = ctrl_i.tile_e;
        col_limit = ctrl_i.embed_size;
      end
      default: ;
    endcase
  end

  assign active     = (step_q != step_idle);
  assign stall      = (ongoing_q >= FIFO_DEPTH);
  assign last_inner = active && (inner_q == n_inner - 1'b1);

  // readies cross over to the partner valid
  assign inp_ready_o    = active && !stall && weight_valid_i;
  assign weight_ready_o = active && !stall && inp_valid_i;
  assign bias_ready_o   = active && !stall && weight_valid_i;
  assign accept         = active && !stall && inp_valid_i && weight_valid_i && bias_valid_i;

  assign calc_en_o          = accept;
  assign busy_o             = active;
  assign first_inner_tile_o = active && (inner_q == '0);
  assign last_inner_tile_o  = last_inner;
  assign step_o             = step_q;
  assign tile_x_o           = tile_x_q;
  assign tile_y_o           = tile_y_q;
  assign inner_tile_o       = inner_q;

  always_comb begin
    step_d   = step_q;
    count_d  = count_q;
    inner_d  = inner_q;
    tile_x_d = tile_x_q;
    tile_y_d = tile_y_q;
    if (!active) begin
      if (ctrl_i.start) begin
        step_d = (ctrl_i.layer == layer_feedforward) ? step_f1 : step_matmul;
      end
    end else if (accept) begin
      if (count_q != count_t'(BEATS - 1)) begin
        count_d = count_q + 1'b1;
      end else begin
        count_d = '0;
        if (!last_inner) begin
          inner_d = inner_q + 1'b1;
        end else begin
          inner_d = '0;
          if (tile_x_q != n_tile_x - 1'b1) begin  // x wraps first
            tile_x_d = tile_x_q + 1'b1;
          end else begin
            tile_x_d = '0;
            if (tile_y_q != ctrl_i.tile_s - 1'b1) begin
              tile_y_d = tile_y_q + 1'b1;
            end else begin
              tile_y_d = '0;
              step_d   = (step_q == step_f1) ? step_f2 : step_idle;
            end
          end
        end
      end
    end
  end

  // results of the last inner tile land in the output FIFO
  assign push = accept && last_inner;
  assign pop  = oup_valid_i && oup_ready_i;

  always_comb begin
    ongoing_d = ongoing_q;
    if (push && !pop) begin
      ongoing_d = ongoing_q + 1'b1;
    end else if (pop && !push) begin
      ongoing_d = ongoing_q - 1'b1;
    end
  end

  assign row      = dim_t'(count_q % TILE_DIM) + dim_t'(tile_y_q) * dim_t'(TILE_DIM);
  assign col_base = dim_t'(count_q / TILE_DIM) * dim_t'(N_LANES)
                  + dim_t'(tile_x_q) * dim_t'(TILE_DIM);

  assign beat_pos_o = '{
    valid:     accept,
    row_oob:   (row >= ctrl_i.seq_length),
    col_base:  col_base,
    col_limit: col_limit
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q    <= step_idle;
      count_q   <= '0;
      inner_q   <= '0;
      tile_x_q  <= '0;
      tile_y_q  <= '0;
      ongoing_q <= '0;
    end else begin
      step_q    <= step_d;
      count_q   <= count_d;
      inner_q   <= inner_d;
      tile_x_q  <= tile_x_d;
      tile_y_q  <= tile_y_d;
      ongoing_q <= ongoing_d;
    end
  end

endmodule

//--- pad_lane.sv
//########################################
// padding gate for one lane
//########################################

`timescale 1ns/100ps

module pad_lane #(
  parameter int unsigned LANE    = 0,
  parameter int unsigned N_LANES = 4
) (
  input  ita_pkg::beat_pos_t beat_pos_i,
  input  ita_pkg::bias_t     bias_i,
  input  logic               requant_add_i,
  output ita_pkg::bias_t     bias_o,
  output logic               requant_add_o
);
  import ita_pkg::*;

  localparam dim_t OFFSET = dim_t'(LANE % N_LANES);  // column offset from lane 0

  dim_t col;
  logic keep;

  assign col = beat_pos_i.col_base + OFFSET;

  // zero whatever falls outside the output matrix
  assign keep = !beat_pos_i.row_oob && (col < beat_pos_i.col_limit);

  assign bias_o        = keep ? bias_i : '0;
  assign requant_add_o = keep && requant_add_i;

endmodule

//--- pad_output_reg.sv
//########################################
// output register for all padded lanes
//########################################

`timescale 1ns/100ps

module pad_output_reg #(
  parameter int unsigned N_LANES = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          valid_i,
  input  ita_pkg::bias_t [N_LANES-1:0] bias_i,
  input  logic [N_LANES-1:0]            requant_add_i,
  output logic                          pad_valid_o,
  output ita_pkg::bias_t [N_LANES-1:0] bias_pad_o,
  output logic [N_LANES-1:0]            requant_add_o
);
  import ita_pkg::*;

  logic                valid_q;
  bias_t [N_LANES-1:0] bias_q;
  logic [N_LANES-1:0]  requant_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;  // one-cycle pulse per beat
    end
  end

  // data holds until the next accepted beat
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      bias_q    <= bias_i;
      requant_q <= requant_add_i;
    end
  end

  assign pad_valid_o   = valid_q;
  assign bias_pad_o    = bias_q;
  assign requant_add_o = requant_q;

endmodule

//--- ita_tiler_top.sv
//########################################
// tiling controller top level
// sequencer, lane padding gates, output reg
//########################################

`timescale 1ns/100ps

module ita_tiler_top #(
  parameter int unsigned N_LANES    = 4,
  parameter int unsigned TILE_DIM   = 8,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  ita_pkg::ctrl_t                ctrl_i,
  input  logic                          inp_valid_i,
  input  logic                          weight_valid_i,
  input  logic                          bias_valid_i,
  input  logic                          oup_valid_i,
  input  logic                          oup_ready_i,
  input  ita_pkg::bias_t [N_LANES-1:0] inp_bias_i,
  input  logic                          requant_add_i,
  output logic                          inp_ready_o,
  output logic                          weight_ready_o,
  output logic                          bias_ready_o,
  output logic                          calc_en_o,
  output logic                          busy_o,
  output logic                          first_inner_tile_o,
  output logic                          last_inner_tile_o,
  output ita_pkg::step_e                step_o,
  output ita_pkg::tile_t                tile_x_o,
  output ita_pkg::tile_t                tile_y_o,
  output ita_pkg::tile_t                inner_tile_o,
  output ita_pkg::bias_t [N_LANES-1:0] bias_pad_o,
  output logic [N_LANES-1:0]            requant_add_o,
  output logic                          pad_valid_o
);
  import ita_pkg::*;

  beat_pos_t           beat_pos;
  bias_t [N_LANES-1:0] lane_bias;
  logic [N_LANES-1:0]  lane_requant;

  tile_sequencer #(
    .N_LANES    (N_LANES),
    .TILE_DIM   (TILE_DIM),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_sequencer (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .ctrl_i             (ctrl_i),
    .inp_valid_i        (inp_valid_i),
    .weight_valid_i     (weight_valid_i),
    .bias_valid_i       (bias_valid_i),
    .oup_valid_i        (oup_valid_i),
    .oup_ready_i        (oup_ready_i),
    .inp_ready_o        (inp_ready_o),
    .weight_ready_o     (weight_ready_o),
    .bias_ready_o       (bias_ready_o),
    .calc_en_o          (calc_en_o),
    .busy_o             (busy_o),
    .first_inner_tile_o (first_inner_tile_o),
    .last_inner_tile_o  (last_inner_tile_o),
    .step_o             (step_o),
    .tile_x_o           (tile_x_o),
    .tile_y_o           (tile_y_o),
    .inner_tile_o       (inner_tile_o),
    .beat_pos_o         (beat_pos)
  );

  // requant enable is broadcast to every lane
  for (genvar i = 0; i < N_LANES; i++) begin : gen_lane
    pad_lane #(
      .LANE    (i),
      .N_LANES (N_LANES)
    ) u_pad_lane (
      .beat_pos_i    (beat_pos),
      .bias_i        (inp_bias_i[i]),
      .requant_add_i (requant_add_i),
      .bias_o        (lane_bias[i]),
      .requant_add_o (lane_requant[i])
    );
  end

  pad_output_reg #(
    .N_LANES (N_LANES)
  ) u_pad_output_reg (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (beat_pos.valid),
    .bias_i        (lane_bias),
    .requant_add_i (lane_requant),
    .pad_valid_o   (pad_valid_o),
    .bias_pad_o    (bias_pad_o),
    .requant_add_o (requant_add_o)
  );

endmodule

//--- tb_ita_tiler.sv
//########################################
// testbench for the tiling controller
// xorshift stimulus, reference model, watchdog
//########################################

`timescale 1ns/100ps

module tb_ita_tiler;
  import ita_pkg::*;

  localparam int unsigned N_LANES    = 4;
  localparam int unsigned TILE_DIM   = 8;
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned PERIOD     = 100;
  localparam int unsigned BEATS      = TILE_DIM * TILE_DIM / N_LANES;
  // worst case beats of two linear runs, two feedforward runs and the stall run
  localparam int unsigned MAX_BEATS    = 2 * 288 + 2 * 384 + 32;
  localparam int unsigned STALL_FACTOR = 10;
  localparam int unsigned TIMEOUT_NS   = (MAX_BEATS * STALL_FACTOR + 600) * PERIOD;

  logic                 clk_i;
  logic                 rst_ni;
  ctrl_t                ctrl_i;
  logic                 inp_valid_i;
  logic                 weight_valid_i;
  logic                 bias_valid_i;
  logic                 oup_valid_i;
  logic                 oup_ready_i;
  bias_t [N_LANES-1:0]  inp_bias_i;
  logic                 requant_add_i;
  logic                 inp_ready_o;
  logic                 weight_ready_o;
  logic                 bias_ready_o;
  logic                 calc_en_o;
  logic                 busy_o;
  logic                 first_inner_tile_o;
  logic                 last_inner_tile_o;
  step_e                step_o;
  tile_t                tile_x_o;
  tile_t                tile_y_o;
  tile_t                inner_tile_o;
  bias_t [N_LANES-1:0]  bias_pad_o;
  logic [N_LANES-1:0]   requant_add_o;
  logic                 pad_valid_o;

  logic [31:0] rng_state = 32'h22f5f441;
  ctrl_t       ctrl_next;

  // reference model state
  step_e m_step;
  int    m_count, m_inner, m_x, m_y, m_ongoing;
  logic  pend_valid;
  bias_t exp_bias [N_LANES];
  logic  exp_rq [N_LANES];
  int    beats_step [4];
  logic  saw_stall;

  ita_tiler_top #(
    .N_LANES    (N_LANES),
    .TILE_DIM   (TILE_DIM),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Verification failed");
    $fatal(1, "watchdog: test did not finish within %0d ns", TIMEOUT_NS);
  end

  function automatic logic [31:0] rand32();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // loop bounds and column limit of a step
  task automatic get_bounds(input step_e s, output int n_inner, output int n_x,
                            output int limit);
    n_inner = int'(ctrl_i.tile_e);
    n_x     = int'(ctrl_i.tile_p);
    limit   = int'(ctrl_i.proj_space);
    if (s == step_f1) begin
      n_x   = int'(ctrl_i.tile_f);
      limit = int'(ctrl_i.ff_size);
    end else if (s == step_f2) begin
      n_inner = int'(ctrl_i.tile_f);
      n_x     = int'(ctrl_i.tile_e);
      limit   = int'(ctrl_i.embed_size);
    end
  endtask

  // drive on negedge, check in the low phase, then advance the model
  task automatic run_cycle(input bit all_valid, input bit hold_ready);
    logic [31:0] r;
    logic        active, stall, acc, last;
    int          n_inner, n_x, limit, row, col0;
    @(negedge clk_i);
    r              = rand32();
    ctrl_i         = ctrl_next;
    inp_valid_i    = all_valid || (r[1:0] != 2'b00);
    weight_valid_i = all_valid || (r[3:2] != 2'b00);
    bias_valid_i   = all_valid || (r[5:4] != 2'b00);
    requant_add_i  = r[6];
    oup_ready_i    = !hold_ready && (r[7] || r[10]);
    oup_valid_i    = (m_ongoing > 0) && (r[8] || r[9]);
    for (int i = 0; i < N_LANES; i++) begin
      inp_bias_i[i] = bias_t'(rand32());
    end
    #(PERIOD / 4);
    get_bounds(m_step, n_inner, n_x, limit);
    active = (m_step != step_idle);
    stall  = (m_ongoing >= FIFO_DEPTH);
    acc    = active && !stall && inp_valid_i && weight_valid_i && bias_valid_i;
    last   = active && (m_inner == n_inner - 1);
    if (active && stall && inp_valid_i && weight_valid_i && bias_valid_i) saw_stall = 1'b1;
    check_value("inp_ready_o", inp_ready_o, active && !stall && weight_valid_i);
    check_value("weight_ready_o", weight_ready_o, active && !stall && inp_valid_i);
    check_value("bias_ready_o", bias_ready_o, active && !stall && weight_valid_i);
    check_value("calc_en_o", calc_en_o, acc);
    check_value("busy_o", busy_o, active);
    check_value("step_o", step_o, m_step);
    check_value("tile_x_o", tile_x_o, m_x);
    check_value("tile_y_o", tile_y_o, m_y);
    check_value("inner_tile_o", inner_tile_o, m_inner);
    check_value("last_inner_tile_o", last_inner_tile_o, last);
    check_value("first_inner_tile_o", first_inner_tile_o, active && (m_inner == 0));
    check_value("pad_valid_o", pad_valid_o, pend_valid);
    if (pend_valid) begin
      for (int i = 0; i < N_LANES; i++) begin
        check_value($sformatf("bias_pad_o[%0d]", i), bias_pad_o[i], exp_bias[i]);
        check_value($sformatf("requant_add_o[%0d]", i), requant_add_o[i], exp_rq[i]);
      end
    end
    // beats counted as the DUT reports them
    if (calc_en_o) begin
      beats_step[int'(step_o)]++;
    end
    pend_valid = acc;
    if (acc) begin
      row  = m_count % TILE_DIM + m_y * TILE_DIM;
      col0 = (m_count / TILE_DIM) * N_LANES + m_x * TILE_DIM;
      for (int i = 0; i < N_LANES; i++) begin
        if (row < int'(ctrl_i.seq_length) && col0 + i < limit) begin
          exp_bias[i] = inp_bias_i[i];
          exp_rq[i]   = requant_add_i;
        end else begin
          exp_bias[i] = '0;
          exp_rq[i]   = 1'b0;
        end
      end
    end
    // outstanding results rise on the last inner tile and fall on an output handshake
    m_ongoing = m_ongoing + int'(acc && last) - int'(oup_valid_i && oup_ready_i);
    if (!active) begin
      if (ctrl_i.start) m_step = (ctrl_i.layer == layer_feedforward) ? step_f1 : step_matmul;
    end else if (acc) begin
      m_count++;
      if (m_count == BEATS) begin
        m_count = 0;
        m_inner++;
        if (m_inner == n_inner) begin
          m_inner = 0;
          m_x++;
          if (m_x == n_x) begin
            m_x = 0;
            m_y++;
            if (m_y == int'(ctrl_i.tile_s)) begin
              m_y    = 0;
              m_step = (m_step == step_f1) ? step_f2 : step_idle;
            end
          end
        end
      end
    end
  endtask

  // dimension that ends somewhere inside the last tile
  function automatic dim_t dim_for(input int tiles);
    return dim_t'((tiles - 1) * TILE_DIM + 1 + (rand32() % TILE_DIM));
  endfunction

  task automatic run_layer(input layer_e layer, input int ts, input int tp, input int te,
                           input int tf, input int hold);
    int n;
    int per_step;
    ctrl_next.layer      = layer;
    ctrl_next.tile_s     = tile_t'(ts);
    ctrl_next.tile_p     = tile_t'(tp);
    ctrl_next.tile_e     = tile_t'(te);
    ctrl_next.tile_f     = tile_t'(tf);
    ctrl_next.seq_length = dim_for(ts);
    ctrl_next.proj_space = dim_for(tp);
    ctrl_next.embed_size = dim_for(te);
    ctrl_next.ff_size    = dim_for(tf);
    for (int s = 0; s < 4; s++) beats_step[s] = 0;
    ctrl_next.start = 1'b1;
    run_cycle(1'b0, hold > 0);
    ctrl_next.start = 1'b0;
    n = 1;
    while (m_step != step_idle) begin
      run_cycle(1'b0, n < hold);
      n++;
    end
    repeat (3) run_cycle(1'b0, 1'b0);
    if (layer == layer_linear) begin
      check_value("matmul beats", beats_step[int'(step_matmul)], ts * tp * te * BEATS);
    end else begin
      per_step = ts * tf * te * BEATS;
      check_value("f1 beats", beats_step[int'(step_f1)], per_step);
      check_value("f2 beats", beats_step[int'(step_f2)], per_step);
    end
  endtask

  initial begin
    ctrl_i         = '0;
    ctrl_next      = '0;
    rst_ni         = 1'b0;
    inp_valid_i    = 1'b0;
    weight_valid_i = 1'b0;
    bias_valid_i   = 1'b0;
    oup_valid_i    = 1'b0;
    oup_ready_i    = 1'b0;
    inp_bias_i     = '0;
    requant_add_i  = 1'b0;
    m_step         = step_idle;
    m_count        = 0;
    m_inner        = 0;
    m_x            = 0;
    m_y            = 0;
    m_ongoing      = 0;
    pend_valid     = 1'b0;
    saw_stall      = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (5) run_cycle(1'b1, 1'b0);  // idle with all valids high keeps readies low
    for (int k = 0; k < 2; k++) begin
      run_layer(layer_linear, 1 + rand32() % 3, 1 + rand32() % 3, 1 + rand32() % 2, 1, 0);
      run_layer(layer_feedforward, 1 + rand32() % 3, 1, 1 + rand32() % 2,
                1 + rand32() % 2, 0);
    end
    // output back-pressure until the FIFO count saturates
    saw_stall = 1'b0;
    run_layer(layer_linear, 1, 2, 1, 1, 200);
    check_value("stall_seen", saw_stall, 1'b1);
    $display("Verification passed");
    $finish;
  end

endmodule

//--- src.f
ita_pkg.sv
tile_sequencer.sv
pad_lane.sv
pad_output_reg.sv
ita_tiler_top.sv
tb_ita_tiler.sv

//--- Makefile
# Verilator build for the tiling controller testbench

VERILATOR ?= verilator
TOP       ?= tb_ita_tiler
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
EXTRA     ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
